/* Makefile */
TOP := tb_vision_capture

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, look for the pass line"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f list.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

/* dv/tb_vision_capture.sv */
// directed tests only; frame banks alternate from bank 0, one host word per chip select
`timescale 1ns/1ps

module tb_vision_capture;
	import vision_pkg::*;

	logic                  clk_llc;
	logic                  resetx;
	logic [7:0]            vpo;
	logic                  vref;
	logic                  href;
	logic [MEM_ADDR_W-1:0] host_addr;
	logic                  host_csx;
	logic                  host_rdx;
	class_flags_t          host_rdata;
	logic                  host_waitx;
	logic                  irq_bank0;
	logic                  irq_bank1;

	// one frame of bytes, Cb Y0 Cr Y1 per group
	logic [7:0]  frame_bytes [0:2*FRAME_PIXELS-1];
	// expected flags, indexed like the memory
	logic [5:0]  exp_flags [0:2*FRAME_PIXELS-1];
	logic [31:0] lcg_state;
	int          errors;
	int          checks;
	// interrupt bookkeeping
	int          irq_pulses;
	int          irq0_cycles;
	int          irq1_cycles;
	int          mark_pulses;
	int          mark0;
	int          mark1;
	logic        irq_any_d;

	vision_capture_top dut0 (
		.clk_llc    (clk_llc),
		.resetx     (resetx),
		.vpo        (vpo),
		.vref       (vref),
		.href       (href),
		.host_addr  (host_addr),
		.host_csx   (host_csx),
		.host_rdx   (host_rdx),
		.host_rdata (host_rdata),
		.host_waitx (host_waitx),
		.irq_bank0  (irq_bank0),
		.irq_bank1  (irq_bank1)
	);

	initial
	begin
		clk_llc = 1'b0;
		forever
			#5 clk_llc = ~clk_llc;
	end

	// interrupt monitor, sampled mid-cycle
	always @(negedge clk_llc)
	begin
		if (resetx)
		begin
			if (irq_bank0 && irq_bank1)
			begin
				$display("ERROR at %0t: irq_bank0 and irq_bank1 are high together", $time);
				errors++;
			end
			if (irq_bank0)
				irq0_cycles++;
			if (irq_bank1)
				irq1_cycles++;
			if ((irq_bank0 || irq_bank1) && !irq_any_d)
				irq_pulses++;
		end
		irq_any_d = irq_bank0 || irq_bank1;
	end

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	function automatic int sat_channel(input int sum);
		int v;
		v = sum >>> 8;
		if (v < 0)
			return 0;
		if (v > 255)
			return 255;
		return v;
	endfunction

	// open interval test
	function automatic logic hue_inside(input int h, input int lo, input int hi);
		return (h > lo) && (h < hi);
	endfunction

	function automatic logic [5:0] expected_flags(input int cb, input int y, input int cr);
		int   dy, dcb, dcr;
		int   r, g, b, mx, mn, delta, h, s, tol;
		logic black, chroma, red;
		dy  = int'(COEF_Y) * (y - int'(Y_OFFSET));
		dcb = cb - int'(C_OFFSET);
		dcr = cr - int'(C_OFFSET);
		r   = sat_channel(dy + int'(COEF_CR_R) * dcr);
		g   = sat_channel(dy - int'(COEF_CR_G) * dcr - int'(COEF_CB_G) * dcb);
		b   = sat_channel(dy + int'(COEF_CB_B) * dcb);
		mx  = (r > g) ? r : g;
		mx  = (b > mx) ? b : mx;
		mn  = (r < g) ? r : g;
		mn  = (b < mn) ? b : mn;
		delta = mx - mn;
		s   = (mx == 0) ? 0 : delta * 255 / mx;
		// ties go to red, then green
		if (delta == 0)
			h = 0;
		else if (r >= g && r >= b)
		begin
			h = HUE_SECTOR * (g - b) / delta;
			if (h < 0)
				h = h + HUE_RANGE;
		end
		else if (g >= b)
			h = 2 * HUE_SECTOR + HUE_SECTOR * (b - r) / delta;
		else
			h = 4 * HUE_SECTOR + HUE_SECTOR * (r - g) / delta;
		tol    = int'(H_TOL);
		black  = mx < int'(V_BLACK);
		chroma = !black && (s > int'(S_MIN));
		// red window seen once more one full turn up the hue circle
		red    = hue_inside(h, int'(HUE_RED) - tol, int'(HUE_RED) + tol) ||
			hue_inside(h + HUE_RANGE, int'(HUE_RED) - tol, int'(HUE_RED) + tol);
		return {chroma && red,
			chroma && hue_inside(h, int'(HUE_ORANGE) - tol, int'(HUE_ORANGE) + tol),
			chroma && hue_inside(h, int'(HUE_YELLOW) - tol, int'(HUE_YELLOW) + tol),
			chroma && hue_inside(h, int'(HUE_GREEN) - tol, int'(HUE_GREEN) + tol),
			chroma && hue_inside(h, int'(HUE_BLUE) - tol, int'(HUE_BLUE) + tol),
			black};
	endfunction

	task automatic compute_expected(input int bank);
		int i;
		int base;
		for (i = 0; i < FRAME_PIXELS; i++)
		begin
			// two pixels per group, both share Cb and Cr
			base = 4 * (i / 2);
			exp_flags[bank * FRAME_PIXELS + i] = expected_flags(frame_bytes[base],
				frame_bytes[base + 1 + 2 * (i % 2)], frame_bytes[base + 2]);
		end
	endtask

	// ----------------------------------------
	// stimulus helpers
	// ----------------------------------------
	function automatic logic [7:0] lcg_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:24];
	endfunction

	// {Cb, Y, Cr}, studio range
	function automatic logic [23:0] primary_triple(input int k);
		case (k % 8)
			0: return {8'd90, 8'd81, 8'd240};
			1: return {8'd54, 8'd145, 8'd34};
			// sky blue, hue near 145
			2: return {8'd211, 8'd91, 8'd73};
			3: return {8'd16, 8'd210, 8'd146};
			// orange, hue near 20
			4: return {8'd53, 8'd146, 8'd193};
			5: return {8'd128, 8'd16, 8'd128};
			6: return {8'd128, 8'd126, 8'd128};
			default: return {8'd128, 8'd235, 8'd128};
		endcase
	endfunction

	task automatic fill_primary();
		int          grp;
		logic [23:0] t;
		for (grp = 0; grp < FRAME_PIXELS / 2; grp++)
		begin
			t = primary_triple(grp);
			frame_bytes[4 * grp]     = t[23:16];
			frame_bytes[4 * grp + 1] = t[15:8];
			frame_bytes[4 * grp + 2] = t[7:0];
			frame_bytes[4 * grp + 3] = t[15:8];
		end
	endtask

	task automatic fill_random();
		int i;
		for (i = 0; i < 2 * FRAME_PIXELS; i++)
			frame_bytes[i] = lcg_byte();
	endtask

	// vref frame, href per line, gaps between lines
	task automatic send_frame();
		int line;
		int k;
		@(negedge clk_llc);
		vref = 1'b1;
		repeat (3) @(negedge clk_llc);
		for (line = 0; line < FRAME_LINES; line++)
		begin
			for (k = 0; k < 2 * LINE_PIXELS; k++)
			begin
				href = 1'b1;
				vpo  = frame_bytes[line * 2 * LINE_PIXELS + k];
				@(negedge clk_llc);
			end
			href = 1'b0;
			vpo  = 8'h00;
			repeat (4) @(negedge clk_llc);
		end
		// falling vref closes the frame
		vref = 1'b0;
		repeat (4) @(negedge clk_llc);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
		checks++;
		if (got !== expected)
		begin
			errors++;
			$display("MISMATCH time=%0t %s got=0x%0h expected=0x%0h", $time, name, got, expected);
		end
	endtask

	task automatic host_read(input logic [MEM_ADDR_W-1:0] addr, output logic [5:0] data);
		int n;
		@(negedge clk_llc);
		host_addr = addr;
		host_csx  = 1'b0;
		host_rdx  = 1'b0;
		n = 0;
		// waitx drops one cycle after the strobes
		do
		begin
			@(negedge clk_llc);
			n++;
		end
		while (host_waitx && n < 10);
		if (host_waitx)
		begin
			$display("ERROR at %0t: host_waitx never went low for address %0d", $time, addr);
			errors++;
		end
		n = 0;
		while (!host_waitx && n < 40)
		begin
			@(negedge clk_llc);
			n++;
		end
		if (!host_waitx)
		begin
			$display("ERROR at %0t: host read of address %0d timed out", $time, addr);
			errors++;
		end
		data     = host_rdata;
		host_csx = 1'b1;
		host_rdx = 1'b1;
	endtask

	task automatic read_bank(input int bank);
		int                    i;
		logic [MEM_ADDR_W-1:0] addr;
		logic [5:0]            data;
		for (i = 0; i < FRAME_PIXELS; i++)
		begin
			addr = bank * FRAME_PIXELS + i;
			host_read(addr, data);
			check($sformatf("host_rdata[%0d]", addr), data, exp_flags[addr]);
		end
	endtask

	task automatic mark_irq();
		mark_pulses = irq_pulses;
		mark0       = irq0_cycles;
		mark1       = irq1_cycles;
	endtask

	// exactly one pulse, on the bank just filled
	task automatic check_frame_irq(input int bank);
		int n;
		n = 0;
		while (irq_pulses == mark_pulses && n < 400)
		begin
			@(negedge clk_llc);
			n++;
		end
		if (irq_pulses == mark_pulses)
		begin
			$display("ERROR at %0t: no frame interrupt for bank %0d", $time, bank);
			errors++;
		end
		n = 0;
		while ((irq_bank0 || irq_bank1) && n < 20)
		begin
			@(negedge clk_llc);
			n++;
		end
		if (irq_bank0 || irq_bank1)
		begin
			$display("ERROR at %0t: frame interrupt stays high", $time);
			errors++;
		end
		check("irq pulses", irq_pulses - mark_pulses, 1);
		check("irq_bank0 cycles", irq0_cycles - mark0, (bank == 0) ? int'(IRQ_CYCLES) : 0);
		check("irq_bank1 cycles", irq1_cycles - mark1, (bank == 1) ? int'(IRQ_CYCLES) : 0);
	endtask

	task automatic run_frame(input int bank);
		mark_irq();
		send_frame();
		check_frame_irq(bank);
	endtask

	// ----------------------------------------
	// directed tests
	// ----------------------------------------
	task automatic check_reset_state();
		logic [5:0] data;
		check("host_waitx", host_waitx, 1);
		check("irq_bank0", irq_bank0, 0);
		check("irq_bank1", irq_bank1, 0);
		// memory still unwritten, only the handshake matters
		host_read('0, data);
		@(negedge clk_llc);
		check("host_waitx", host_waitx, 1);
	endtask

	task automatic primary_colours();
		fill_primary();
		compute_expected(0);
		run_frame(0);
		read_bank(0);
	endtask

	task automatic frame_interrupts();
		fill_random();
		compute_expected(1);
		run_frame(1);
		read_bank(1);
	endtask

	task automatic random_frames();
		int f;
		for (f = 0; f < 3; f++)
		begin
			fill_random();
			compute_expected(f % 2);
			run_frame(f % 2);
			read_bank(f % 2);
		end
	endtask

	// bank 0 holds the last random frame while bank 1 fills
	task automatic read_during_capture();
		fill_random();
		compute_expected(1);
		mark_irq();
		fork
			send_frame();
			read_bank(0);
		join
		check_frame_irq(1);
		read_bank(1);
	endtask

	task automatic end_test(input string name, input int err_start);
		$display("test %s: %s, %0d errors", name, (errors == err_start) ? "ok" : "failed",
			errors - err_start);
	endtask

	initial
	begin
		int e;
		resetx      = 1'b0;
		vpo         = 8'h00;
		vref        = 1'b0;
		href        = 1'b0;
		host_addr   = '0;
		host_csx    = 1'b1;
		host_rdx    = 1'b1;
		lcg_state   = 32'hb17eac5f;
		errors      = 0;
		checks      = 0;
		irq_pulses  = 0;
		irq0_cycles = 0;
		irq1_cycles = 0;
		irq_any_d   = 1'b0;
		repeat (10) @(posedge clk_llc);
		@(negedge clk_llc);
		resetx = 1'b1;

		e = errors;
		check_reset_state();
		end_test("reset state", e);
		// bank 0
		e = errors;
		primary_colours();
		end_test("primary colours", e);
		// bank 1
		e = errors;
		frame_interrupts();
		end_test("frame interrupts", e);
		// banks 0, 1, 0
		e = errors;
		random_frames();
		end_test("random frames", e);
		e = errors;
		read_during_capture();
		end_test("read during capture", e);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* list.f */
verilog/vision_pkg.sv
verilog/ycbcr_to_rgb.sv
verilog/rgb_to_hsv.sv
verilog/color_classifier.sv
verilog/frame_writer.sv
verilog/frame_buffer.sv
verilog/vision_capture_top.sv
dv/tb_vision_capture.sv

/* verilog/color_classifier.sv */
// one-clock classifier; colour windows may overlap, black excludes all colours
`timescale 1ns/1ps

module color_classifier (
	input  logic                     clk_llc,
	input  logic                     resetx,
	input  vision_pkg::hsv_pixel_t   hsv_in,
	output vision_pkg::class_pixel_t class_out
);
	import vision_pkg::*;

	logic is_black, chroma;

	// open window of +-H_TOL around a centre
	function automatic logic in_window(input logic [7:0] h, input logic [7:0] centre);
		return (h > centre - H_TOL) && (h < centre + H_TOL);
	endfunction

	assign is_black = hsv_in.v < V_BLACK;
	assign chroma   = !is_black && (hsv_in.s > S_MIN);

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
			class_out <= '0;
		else
		begin
			class_out.valid        <= hsv_in.valid;
			class_out.eof          <= hsv_in.eof;
			class_out.flags.black  <= is_black;
			// red straddles the 239 -> 0 wrap
			class_out.flags.red    <= chroma && ((hsv_in.h > HUE_RED - H_TOL) ||
				(hsv_in.h < HUE_RED + H_TOL - HUE_RANGE));
			class_out.flags.orange <= chroma && in_window(hsv_in.h, HUE_ORANGE);
			class_out.flags.yellow <= chroma && in_window(hsv_in.h, HUE_YELLOW);
			class_out.flags.green  <= chroma && in_window(hsv_in.h, HUE_GREEN);
			class_out.flags.blue   <= chroma && in_window(hsv_in.h, HUE_BLUE);
		end
	end

	// black pixels carry no colour
	assert property (@(posedge clk_llc) disable iff (!resetx)
		class_out.valid |-> !(class_out.flags.black && (class_out.flags.red ||
		class_out.flags.orange || class_out.flags.yellow || class_out.flags.green ||
		class_out.flags.blue)));

endmodule

/* verilog/frame_buffer.sv */
// single-port memory; capture writes win, host read stretches waitx until data is out
`timescale 1ns/1ps

module frame_buffer (
	input  logic                              clk_llc,
	input  logic                              resetx,
	input  logic                              wr_en,
	input  logic [vision_pkg::MEM_ADDR_W-1:0] wr_addr,
	input  vision_pkg::class_flags_t          wr_data,
	input  logic [vision_pkg::MEM_ADDR_W-1:0] host_addr,
	input  logic                              host_csx,
	input  logic                              host_rdx,
	output vision_pkg::class_flags_t          host_rdata,
	output logic                              host_waitx
);
	import vision_pkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_LATCH, ST_HOLD} host_state_t;

	// two banks back to back, bank bit on top
	class_flags_t mem [0:2*FRAME_PIXELS-1];
	class_flags_t mem_q;
	host_state_t  state;
	logic         rd_go;
	logic         busy;

	// host slot only when capture is quiet
	assign rd_go = (state == ST_READ) && !host_csx && !wr_en;
	assign busy  = (state == ST_READ) || (state == ST_LATCH);

	always_ff @(posedge clk_llc)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		else if (rd_go)
			mem_q <= mem[host_addr];
		if (state == ST_LATCH)
			host_rdata <= mem_q;
	end

	// ----------------------------------------
	// host port FSM
	// ----------------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
			state <= ST_IDLE;
		else
		begin
			case (state)
				ST_IDLE:
					if (!host_csx && !host_rdx)
						state <= ST_READ;
				ST_READ:
					if (host_csx)
						state <= ST_IDLE;
					else if (rd_go)
						state <= ST_LATCH;
				ST_LATCH:
					state <= host_csx ? ST_IDLE : ST_HOLD;
				default:
					// one read per chip select
					if (host_csx)
						state <= ST_IDLE;
			endcase
		end
	end

	assign host_waitx = host_csx || !busy;

	assert property (@(posedge clk_llc) disable iff (!resetx)
		host_csx |-> host_waitx);

endmodule

/* verilog/frame_writer.sv */
// first frame after reset fills bank 0; pixels past FRAME_PIXELS are dropped
`timescale 1ns/1ps

module frame_writer (
	input  logic                                clk_llc,
	input  logic                                resetx,
	input  vision_pkg::class_pixel_t            class_in,
	output logic                                wr_en,
	output logic [vision_pkg::MEM_ADDR_W-1:0]   wr_addr,
	output vision_pkg::class_flags_t            wr_data,
	output logic                                irq_bank0,
	output logic                                irq_bank1
);
	import vision_pkg::*;

	// one extra bit to see the frame overflow
	logic [PIX_ADDR_W:0] pix_idx;
	logic                bank;
	logic                irq_sel;
	logic [$bits(IRQ_CYCLES)-1:0] irq_cnt;
	logic                room;

	assign room = pix_idx < FRAME_PIXELS;

	// ----------------------------------------
	// index, bank and interrupt pulse
	// ----------------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			pix_idx <= '0;
			bank    <= 1'b0;
			irq_sel <= 1'b0;
			irq_cnt <= '0;
			wr_en   <= 1'b0;
		end
		else
		begin
			wr_en <= class_in.valid && room;
			if (class_in.eof)
			begin
				// report the bank just filled, then swap
				irq_cnt <= IRQ_CYCLES;
				irq_sel <= bank;
				bank    <= !bank;
				pix_idx <= '0;
			end
			else
			begin
				if (irq_cnt != '0)
					irq_cnt <= irq_cnt - 1'b1;
				if (class_in.valid && room)
					pix_idx <= pix_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_llc)
	begin
		wr_addr <= {bank, pix_idx[PIX_ADDR_W-1:0]};
		wr_data <= class_in.flags;
	end

	assign irq_bank0 = (irq_cnt != '0) && !irq_sel;
	assign irq_bank1 = (irq_cnt != '0) && irq_sel;

	assert property (@(posedge clk_llc) disable iff (!resetx)
		!(irq_bank0 && irq_bank1));

endmodule

/* verilog/rgb_to_hsv.sv */
// four-stage pipeline, new pixel every clock; hue 0..239, ties resolve R then G
`timescale 1ns/1ps

module rgb_to_hsv (
	input  logic                   clk_llc,
	input  logic                   resetx,
	input  vision_pkg::rgb_pixel_t rgb_in,
	output vision_pkg::hsv_pixel_t hsv_out
);
	import vision_pkg::*;

	logic [3:0] vld_sr, eof_sr;
	logic       mx_r, mx_g;
	logic [7:0] mx, mn;
	// stage 1
	logic [7:0] s1_r, s1_g, s1_b, s1_max, s1_min;
	logic       s1_max_r, s1_max_g;
	// stage 2
	logic [7:0] s2_max, s2_delta;
	logic signed [8:0] s2_diff;
	logic       s2_max_r, s2_max_g;
	// stage 3
	logic [15:0] sat_full;
	logic signed [15:0] hue_num, hue_quo;
	logic [7:0] s3_v, s3_s;
	logic signed [7:0] s3_hq;
	logic       s3_zero, s3_max_r, s3_max_g;
	// stage 4
	logic signed [9:0] hue_base, hue_sum;
	logic [7:0] s4_h, s4_s, s4_v;

	// valid/eof ride their own chain
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			vld_sr <= '0;
			eof_sr <= '0;
		end
		else
		begin
			vld_sr <= {vld_sr[2:0], rgb_in.valid};
			eof_sr <= {eof_sr[2:0], rgb_in.eof};
		end
	end

	// ----------------------------------------
	// combinational parts per stage
	// ----------------------------------------
	always_comb
	begin
		// which channel wins the max
		mx_r = (rgb_in.r >= rgb_in.g) && (rgb_in.r >= rgb_in.b);
		mx_g = !mx_r && (rgb_in.g >= rgb_in.b);
		mx   = mx_r ? rgb_in.r : (mx_g ? rgb_in.g : rgb_in.b);
		mn   = (rgb_in.r <= rgb_in.g) ? rgb_in.r : rgb_in.g;
		mn   = (rgb_in.b < mn) ? rgb_in.b : mn;
		// saturation and signed hue quotient
		sat_full = (s2_max == 8'd0) ? 16'd0 : (s2_delta * 16'd255) / {8'd0, s2_max};
		hue_num  = 16'(HUE_SECTOR * s2_diff);
		hue_quo  = (s2_delta == 8'd0) ? 16'sd0 : hue_num / $signed({1'b0, s2_delta});
		// sector base, red wraps negatives
		if (s3_max_r)
			hue_base = (s3_hq < 0) ? 10'(HUE_RANGE) : 10'sd0;
		else if (s3_max_g)
			hue_base = 10'(2 * HUE_SECTOR);
		else
			hue_base = 10'(4 * HUE_SECTOR);
		hue_sum = hue_base + 10'(s3_hq);
	end

	// ----------------------------------------
	// pipeline registers
	// ----------------------------------------
	always_ff @(posedge clk_llc)
	begin
		s1_r     <= rgb_in.r;
		s1_g     <= rgb_in.g;
		s1_b     <= rgb_in.b;
		s1_max   <= mx;
		s1_min   <= mn;
		s1_max_r <= mx_r;
		s1_max_g <= mx_g;
		// difference picked by the winning channel
		s2_max   <= s1_max;
		s2_delta <= s1_max - s1_min;
		s2_max_r <= s1_max_r;
		s2_max_g <= s1_max_g;
		if (s1_max_r)
			s2_diff <= $signed({1'b0, s1_g}) - $signed({1'b0, s1_b});
		else if (s1_max_g)
			s2_diff <= $signed({1'b0, s1_b}) - $signed({1'b0, s1_r});
		else
			s2_diff <= $signed({1'b0, s1_r}) - $signed({1'b0, s1_g});
		s3_v     <= s2_max;
		s3_s     <= sat_full[7:0];
		s3_hq    <= hue_quo[7:0];
		s3_zero  <= (s2_delta == 8'd0);
		s3_max_r <= s2_max_r;
		s3_max_g <= s2_max_g;
		// grey pixels have no hue
		s4_h     <= s3_zero ? 8'd0 : hue_sum[7:0];
		s4_s     <= s3_s;
		s4_v     <= s3_v;
	end

	assign hsv_out = '{valid: vld_sr[3], eof: eof_sr[3], h: s4_h, s: s4_s, v: s4_v};

endmodule

/* verilog/vision_capture_top.sv */
// everything on clk_llc; capture never stalls, host reads wait on host_waitx
`timescale 1ns/1ps

module vision_capture_top (
	input  logic                              clk_llc,
	input  logic                              resetx,
	input  logic [7:0]                        vpo,
	input  logic                              vref,
	input  logic                              href,
	input  logic [vision_pkg::MEM_ADDR_W-1:0] host_addr,
	input  logic                              host_csx,
	input  logic                              host_rdx,
	output vision_pkg::class_flags_t          host_rdata,
	output logic                              host_waitx,
	output logic                              irq_bank0,
	output logic                              irq_bank1
);
	import vision_pkg::*;

	rgb_pixel_t              rgb_s;
	hsv_pixel_t              hsv_s;
	class_pixel_t            class_s;
	logic                    wr_en;
	logic [MEM_ADDR_W-1:0]   wr_addr;
	class_flags_t            wr_data;

	// ----------------------------------------
	// pixel chain, 9 clocks byte to write
	// ----------------------------------------
	ycbcr_to_rgb u_ycc (
		.clk_llc (clk_llc),
		.resetx  (resetx),
		.vpo     (vpo),
		.vref    (vref),
		.href    (href),
		.rgb_out (rgb_s)
	);

	rgb_to_hsv u_hsv (
		.clk_llc (clk_llc),
		.resetx  (resetx),
		.rgb_in  (rgb_s),
		.hsv_out (hsv_s)
	);

	color_classifier u_cls (
		.clk_llc   (clk_llc),
		.resetx    (resetx),
		.hsv_in    (hsv_s),
		.class_out (class_s)
	);

	frame_writer u_wr (
		.clk_llc   (clk_llc),
		.resetx    (resetx),
		.class_in  (class_s),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.irq_bank0 (irq_bank0),
		.irq_bank1 (irq_bank1)
	);

	// host side
	frame_buffer u_fb (
		.clk_llc    (clk_llc),
		.resetx     (resetx),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.host_addr  (host_addr),
		.host_csx   (host_csx),
		.host_rdx   (host_rdx),
		.host_rdata (host_rdata),
		.host_waitx (host_waitx)
	);

endmodule

/* verilog/vision_pkg.sv */
// single clk_llc domain; tiny fixed frame; hue on a 0..239 scale, not degrees
package vision_pkg;

	// ----------------------------------------
	// frame geometry
	// ----------------------------------------
	// 4 Cb-Y-Cr-Y groups per line
	localparam int unsigned LINE_PIXELS  = 8;
	localparam int unsigned FRAME_LINES  = 4;
	localparam int unsigned FRAME_PIXELS = LINE_PIXELS * FRAME_LINES;
	localparam int unsigned PIX_ADDR_W   = $clog2(FRAME_PIXELS);
	// bank bit sits on top of the pixel index
	localparam int unsigned MEM_ADDR_W   = PIX_ADDR_W + 1;

	// ----------------------------------------
	// ycbcr to rgb, 8 fractional bits
	// ----------------------------------------
	localparam logic [9:0] COEF_Y    = 10'd298;
	localparam logic [9:0] COEF_CR_R = 10'd408;
	localparam logic [9:0] COEF_CR_G = 10'd208;
	localparam logic [9:0] COEF_CB_G = 10'd100;
	localparam logic [9:0] COEF_CB_B = 10'd516;
	localparam logic [7:0] Y_OFFSET  = 8'd16;
	localparam logic [7:0] C_OFFSET  = 8'd128;

	// hue scale, six sectors of 40
	localparam int HUE_RANGE  = 240;
	localparam int HUE_SECTOR = 40;

	// ----------------------------------------
	// classifier thresholds
	// ----------------------------------------
	localparam logic [7:0] V_BLACK    = 8'd32;
	localparam logic [7:0] S_MIN      = 8'd64;
	localparam logic [7:0] H_TOL      = 8'd15;
	localparam logic [7:0] HUE_RED    = 8'd230;
	localparam logic [7:0] HUE_ORANGE = 8'd15;
	localparam logic [7:0] HUE_YELLOW = 8'd36;
	localparam logic [7:0] HUE_GREEN  = 8'd90;
	localparam logic [7:0] HUE_BLUE   = 8'd144;

	// frame interrupt pulse length in clocks
	localparam logic [1:0] IRQ_CYCLES = 2'd2;

	// memory word and host read data
	typedef struct packed {
		logic red;
		logic orange;
		logic yellow;
		logic green;
		logic blue;
		logic black;
	} class_flags_t;

	// eof comes with valid low, behind the last pixel
	typedef struct packed {
		logic       valid;
		logic       eof;
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_pixel_t;

	typedef struct packed {
		logic       valid;
		logic       eof;
		logic [7:0] h;
		logic [7:0] s;
		logic [7:0] v;
	} hsv_pixel_t;

	typedef struct packed {
		logic         valid;
		logic         eof;
		class_flags_t flags;
	} class_pixel_t;

endpackage

/* verilog/ycbcr_to_rgb.sv */
// expects Cb-Y-Cr-Y byte order from phase 0 of each href; one pixel per luma byte
`timescale 1ns/1ps

module ycbcr_to_rgb (
	input  logic                   clk_llc,
	input  logic                   resetx,
	input  logic [7:0]             vpo,
	input  logic                   vref,
	input  logic                   href,
	output vision_pkg::rgb_pixel_t rgb_out
);
	import vision_pkg::*;

	logic [1:0] phase;
	logic       vref_d;
	logic [7:0] cb_q, y0_q, cr_q, y1_q;
	logic       pend_vld, pend_eof, pend_luma1;
	logic [7:0] y_sel;
	logic signed [8:0]  y_off, cb_off, cr_off;
	logic signed [19:0] prod_y, prod_cr_r, prod_cr_g, prod_cb_g, prod_cb_b;
	logic       s1_vld, s1_eof, s2_vld, s2_eof;
	logic [7:0] r_q, g_q, b_q;

	// shift out the fraction, saturate to 0..255
	function automatic logic [7:0] clamp8(input logic signed [19:0] sum);
		logic signed [19:0] shr;
		shr = sum >>> 8;
		if (sum < 0)
			return 8'd0;
		else if (shr > 20'sd255)
			return 8'hff;
		return shr[7:0];
	endfunction

	// ----------------------------------------
	// byte phase and sample capture
	// ----------------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			phase    <= '0;
			vref_d   <= 1'b0;
			pend_vld <= 1'b0;
			pend_eof <= 1'b0;
		end
		else
		begin
			// phase restarts on every href low
			phase    <= (vref && href) ? phase + 2'd1 : 2'd0;
			vref_d   <= vref;
			// pixel ready once Cr (phase 2) or Y1 (phase 3) is in
			pend_vld <= vref && href && phase[1];
			pend_eof <= vref_d && !vref;
		end
	end

	always_ff @(posedge clk_llc)
	begin
		if (vref && href)
		begin
			case (phase)
				2'd0: cb_q <= vpo;
				2'd1: y0_q <= vpo;
				2'd2: cr_q <= vpo;
				default: y1_q <= vpo;
			endcase
		end
		pend_luma1 <= phase[0];
	end

	always_comb
	begin
		y_sel  = pend_luma1 ? y1_q : y0_q;
		y_off  = $signed({1'b0, y_sel}) - $signed({1'b0, Y_OFFSET});
		cb_off = $signed({1'b0, cb_q}) - $signed({1'b0, C_OFFSET});
		cr_off = $signed({1'b0, cr_q}) - $signed({1'b0, C_OFFSET});
	end

	// ----------------------------------------
	// stage 1 products, stage 2 sum and clamp
	// ----------------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			s1_vld <= 1'b0;
			s1_eof <= 1'b0;
			s2_vld <= 1'b0;
			s2_eof <= 1'b0;
		end
		else
		begin
			s1_vld <= pend_vld;
			s1_eof <= pend_eof;
			s2_vld <= s1_vld;
			s2_eof <= s1_eof;
		end
	end

	always_ff @(posedge clk_llc)
	begin
		prod_y    <= $signed({1'b0, COEF_Y}) * y_off;
		prod_cr_r <= $signed({1'b0, COEF_CR_R}) * cr_off;
		prod_cr_g <= $signed({1'b0, COEF_CR_G}) * cr_off;
		prod_cb_g <= $signed({1'b0, COEF_CB_G}) * cb_off;
		prod_cb_b <= $signed({1'b0, COEF_CB_B}) * cb_off;
		r_q       <= clamp8(prod_y + prod_cr_r);
		g_q       <= clamp8(prod_y - prod_cr_g - prod_cb_g);
		b_q       <= clamp8(prod_y + prod_cb_b);
	end

	assign rgb_out = '{valid: s2_vld, eof: s2_eof, r: r_q, g: g_q, b: b_q};

endmodule
